// File: Makefile
# Verilator build and run for the SD host Wishbone front end

VERILATOR ?= verilator
TOP       ?= tb_sd_host
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// File: common/sd_host_config.svh
`ifndef SD_HOST_CONFIG_SVH
`define SD_HOST_CONFIG_SVH

// bus widths
`define SD_ADR_W        5
`define SD_DATA_W       128

// plain registers at 0..15, the last one is the status word
`define SD_NUM_REGS     16
`define SD_STATUS_REG   15

// execute and fifo ports, 20..31 unmapped
`define SD_ADR_CMD      16
`define SD_ADR_FIFO_WR  17
`define SD_ADR_FIFO_RD  18
`define SD_ADR_DATA     19

// fifo sizing, count has to hold DEPTH itself
`define SD_FIFO_DEPTH   8
`define SD_CNT_W        4

// status word layout
`define SD_ST_CMD_BUSY  0
`define SD_ST_DATA_BUSY 1
`define SD_ST_WCNT_LSB  8
`define SD_ST_RCNT_LSB  16

`endif

// File: common/sd_host_pkg.sv
`include "sd_host_config.svh"

package sd_host_pkg;

	// command word as written to address 16
	// upper part is unused by the card side
	typedef struct packed {
		logic [`SD_DATA_W-41:0] reserved;
		logic [1:0]             resp_type;
		logic [5:0]             cmd_index;
		logic [31:0]            argument;
	} sd_cmd_fields_t;

	// raw view for bus readback, fields view for issuing the command
	typedef union packed {
		logic [`SD_DATA_W-1:0] raw;
		sd_cmd_fields_t        fields;
	} sd_cmd_word_u;

endpackage

// File: exec/sd_exec_ctrl.sv
`timescale 1ns/100ps
`include "sd_host_config.svh"

module sd_exec_ctrl (
	input  logic                      wb_clock,
	input  logic                      rst_n_i,
	input  logic                      cmd_we_i,
	input  logic                      data_we_i,
	input  logic [`SD_DATA_W-1:0]     word_i,
	input  logic                      cmd_done_i,
	input  logic                      data_done_i,
	output logic                      cmd_start_o,
	output logic [5:0]                cmd_index_o,
	output logic [31:0]               cmd_arg_o,
	output logic [1:0]                cmd_resp_type_o,
	output logic                      data_start_o,
	output logic [`SD_DATA_W-1:0]     data_desc_o,
	output logic                      cmd_busy_o,
	output logic                      data_busy_o,
	output sd_host_pkg::sd_cmd_word_u last_cmd_o,
	output logic [`SD_DATA_W-1:0]     last_desc_o
);

// channel slots in the control vectors
localparam int CH_CMD  = 0;
localparam int CH_DATA = 1;

logic [1:0]                we_v;
logic [1:0]                done_v;
logic [1:0]                start_q;
logic [1:0]                busy_q;
sd_host_pkg::sd_cmd_word_u cmd_word_q;
logic [`SD_DATA_W-1:0]     desc_q;

assign we_v[CH_CMD]    = cmd_we_i;
assign we_v[CH_DATA]   = data_we_i;
assign done_v[CH_CMD]  = cmd_done_i;
assign done_v[CH_DATA] = data_done_i;

// start is a one-cycle echo of the write, busy holds until done
always_ff @(posedge wb_clock or negedge rst_n_i)
begin
	if (!rst_n_i)
	begin
		start_q <= '0;
		busy_q <= '0;
	end
	else
	begin
		start_q <= we_v;
		busy_q <= we_v | (busy_q & ~done_v);
	end
end

// last words stay readable over the bus
always_ff @(posedge wb_clock or negedge rst_n_i)
begin
	if (!rst_n_i)
	begin
		cmd_word_q <= '0;
		desc_q <= '0;
	end
	else
	begin
		if (cmd_we_i)
			cmd_word_q <= word_i;
		if (data_we_i)
			desc_q <= word_i;
	end
end

assign cmd_start_o     = start_q[CH_CMD];
assign data_start_o    = start_q[CH_DATA];
assign cmd_busy_o      = busy_q[CH_CMD];
assign data_busy_o     = busy_q[CH_DATA];

// command fields straight from the decoded view
assign cmd_index_o     = cmd_word_q.fields.cmd_index;
assign cmd_arg_o       = cmd_word_q.fields.argument;
assign cmd_resp_type_o = cmd_word_q.fields.resp_type;
assign last_cmd_o      = cmd_word_q;

// descriptor goes out untouched
assign data_desc_o     = desc_q;
assign last_desc_o     = desc_q;

// bus side must refuse a new write while the channel runs
a_no_write_busy: assert property (@(posedge wb_clock) disable iff (!rst_n_i)
	(we_v & busy_q) == 2'b00)
	else $error("execute write while channel busy");

endmodule

// File: fifo/sd_fifo.sv
`timescale 1ns/100ps
`include "sd_host_config.svh"

module sd_fifo #(
	parameter int DEPTH = `SD_FIFO_DEPTH
) (
	input  logic                  wb_clock,
	input  logic                  rst_n_i,
	input  logic                  push_i,
	input  logic [`SD_DATA_W-1:0] data_i,
	input  logic                  pop_i,
	output logic [`SD_DATA_W-1:0] data_o,
	output logic                  full_o,
	output logic                  empty_o,
	output logic [`SD_CNT_W-1:0]  count_o
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam logic [PTR_W-1:0]     LAST_PTR = PTR_W'(DEPTH - 1);
localparam logic [`SD_CNT_W-1:0] FULL_CNT = `SD_CNT_W'(DEPTH);

logic [`SD_DATA_W-1:0] mem [0:DEPTH-1];
logic [PTR_W-1:0]      wr_ptr_q;
logic [PTR_W-1:0]      rd_ptr_q;
logic [`SD_CNT_W-1:0]  count_q;
logic                  do_push;
logic                  do_pop;

assign full_o  = (count_q == FULL_CNT);
assign empty_o = (count_q == '0);
assign do_push = push_i & ~full_o;
assign do_pop  = pop_i & ~empty_o;
assign count_o = count_q;

// head is visible without a pop
assign data_o = mem[rd_ptr_q];

always_ff @(posedge wb_clock)
begin
	if (do_push)
		mem[wr_ptr_q] <= data_i;
end

always_ff @(posedge wb_clock or negedge rst_n_i)
begin
	if (!rst_n_i)
	begin
		wr_ptr_q <= '0;
		rd_ptr_q <= '0;
		count_q <= '0;
	end
	else
	begin
		if (do_push)
			wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
		if (do_pop)
			rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
		// simultaneous push and pop leaves the count alone
		case ({do_push, do_pop})
			2'b10: count_q <= count_q + 1'b1;
			2'b01: count_q <= count_q - 1'b1;
			default: count_q <= count_q;
		endcase
	end
end

a_no_overflow: assert property (@(posedge wb_clock) disable iff (!rst_n_i)
	!(push_i && full_o))
	else $error("push into full fifo");

a_no_underflow: assert property (@(posedge wb_clock) disable iff (!rst_n_i)
	!(pop_i && empty_o))
	else $error("pop from empty fifo");

endmodule

// File: hw/sd_host_wb.sv
`timescale 1ns/100ps
`include "sd_host_config.svh"

module sd_host_wb (
	// wishbone side
	input  logic                  wb_clock,
	input  logic                  rst_n_i,
	input  logic                  strobe_i,
	input  logic                  we_i,
	input  logic [`SD_ADR_W-1:0]  adr_i,
	input  logic [`SD_DATA_W-1:0] wb_data_i,
	output logic [`SD_DATA_W-1:0] wb_data_o,
	output logic                  ack_o,
	output logic                  err_o,
	// sd side
	output logic                  cmd_start_o,
	output logic [5:0]            cmd_index_o,
	output logic [31:0]           cmd_arg_o,
	output logic [1:0]            cmd_resp_type_o,
	input  logic                  cmd_done_i,
	output logic                  data_start_o,
	output logic [`SD_DATA_W-1:0] data_desc_o,
	input  logic                  data_done_i,
	input  logic [`SD_DATA_W-1:0] host_data_i,
	input  logic                  host_data_valid_i,
	output logic [`SD_DATA_W-1:0] host_data_o,
	input  logic                  host_data_pop_i,
	output logic                  fifo_write_wait_o,
	output logic                  fifo_read_wait_o
);

logic                      cmd_we;
logic                      data_we;
logic [`SD_DATA_W-1:0]     exec_word;
logic                      cmd_busy;
logic                      data_busy;
sd_host_pkg::sd_cmd_word_u last_cmd;
logic [`SD_DATA_W-1:0]     last_desc;
logic                      wr_push;
logic [`SD_CNT_W-1:0]      wr_count;
logic                      rd_pop;
logic [`SD_DATA_W-1:0]     rd_head;
logic [`SD_CNT_W-1:0]      rd_count;

wb_regs u_regs (
	.wb_clock    (wb_clock),
	.rst_n_i     (rst_n_i),
	.strobe_i    (strobe_i),
	.we_i        (we_i),
	.adr_i       (adr_i),
	.wb_data_i   (wb_data_i),
	.wb_data_o   (wb_data_o),
	.ack_o       (ack_o),
	.err_o       (err_o),
	.cmd_we_o    (cmd_we),
	.data_we_o   (data_we),
	.exec_word_o (exec_word),
	.cmd_busy_i  (cmd_busy),
	.data_busy_i (data_busy),
	.last_cmd_i  (last_cmd),
	.last_desc_i (last_desc),
	.wr_push_o   (wr_push),
	.wr_full_i   (fifo_write_wait_o),
	.wr_count_i  (wr_count),
	.rd_pop_o    (rd_pop),
	.rd_empty_i  (fifo_read_wait_o),
	.rd_head_i   (rd_head),
	.rd_count_i  (rd_count)
);

sd_exec_ctrl u_exec (
	.wb_clock        (wb_clock),
	.rst_n_i         (rst_n_i),
	.cmd_we_i        (cmd_we),
	.data_we_i       (data_we),
	.word_i          (exec_word),
	.cmd_done_i      (cmd_done_i),
	.data_done_i     (data_done_i),
	.cmd_start_o     (cmd_start_o),
	.cmd_index_o     (cmd_index_o),
	.cmd_arg_o       (cmd_arg_o),
	.cmd_resp_type_o (cmd_resp_type_o),
	.data_start_o    (data_start_o),
	.data_desc_o     (data_desc_o),
	.cmd_busy_o      (cmd_busy),
	.data_busy_o     (data_busy),
	.last_cmd_o      (last_cmd),
	.last_desc_o     (last_desc)
);

// host to card, drained by the sd side
sd_fifo u_wr_fifo (
	.wb_clock (wb_clock),
	.rst_n_i  (rst_n_i),
	.push_i   (wr_push),
	.data_i   (exec_word),
	.pop_i    (host_data_pop_i),
	.data_o   (host_data_o),
	.full_o   (fifo_write_wait_o),
	.empty_o  (),
	.count_o  (wr_count)
);

// card to host, filled by the sd side
sd_fifo u_rd_fifo (
	.wb_clock (wb_clock),
	.rst_n_i  (rst_n_i),
	.push_i   (host_data_valid_i),
	.data_i   (host_data_i),
	.pop_i    (rd_pop),
	.data_o   (rd_head),
	.full_o   (),
	.empty_o  (fifo_read_wait_o),
	.count_o  (rd_count)
);

endmodule

// File: hw/wb_regs.sv
`timescale 1ns/100ps
`include "sd_host_config.svh"

module wb_regs (
	input  logic                      wb_clock,
	input  logic                      rst_n_i,
	input  logic                      strobe_i,
	input  logic                      we_i,
	input  logic [`SD_ADR_W-1:0]      adr_i,
	input  logic [`SD_DATA_W-1:0]     wb_data_i,
	output logic [`SD_DATA_W-1:0]     wb_data_o,
	output logic                      ack_o,
	output logic                      err_o,
	output logic                      cmd_we_o,
	output logic                      data_we_o,
	output logic [`SD_DATA_W-1:0]     exec_word_o,
	input  logic                      cmd_busy_i,
	input  logic                      data_busy_i,
	input  sd_host_pkg::sd_cmd_word_u last_cmd_i,
	input  logic [`SD_DATA_W-1:0]     last_desc_i,
	output logic                      wr_push_o,
	input  logic                      wr_full_i,
	input  logic [`SD_CNT_W-1:0]      wr_count_i,
	output logic                      rd_pop_o,
	input  logic                      rd_empty_i,
	input  logic [`SD_DATA_W-1:0]     rd_head_i,
	input  logic [`SD_CNT_W-1:0]      rd_count_i
);

localparam int REG_IDX_W = $clog2(`SD_NUM_REGS);
localparam logic [`SD_ADR_W-1:0] ADR_STATUS  = `SD_ADR_W'(`SD_STATUS_REG);
localparam logic [`SD_ADR_W-1:0] ADR_CMD     = `SD_ADR_W'(`SD_ADR_CMD);
localparam logic [`SD_ADR_W-1:0] ADR_FIFO_WR = `SD_ADR_W'(`SD_ADR_FIFO_WR);
localparam logic [`SD_ADR_W-1:0] ADR_FIFO_RD = `SD_ADR_W'(`SD_ADR_FIFO_RD);
localparam logic [`SD_ADR_W-1:0] ADR_DATA    = `SD_ADR_W'(`SD_ADR_DATA);

logic                  take;
logic                  legal;
logic                  accept;
logic                  reg_wr;
logic [`SD_DATA_W-1:0] status_word;
logic [`SD_DATA_W-1:0] rd_word;
logic [`SD_DATA_W-1:0] regs_q [0:`SD_NUM_REGS-2];

// new access only when no reply is on the bus
assign take   = strobe_i & ~ack_o & ~err_o;
assign accept = take & legal;
assign reg_wr = accept & we_i & (adr_i < ADR_STATUS);

always_comb
begin
	status_word = '0;
	status_word[`SD_ST_CMD_BUSY] = cmd_busy_i;
	status_word[`SD_ST_DATA_BUSY] = data_busy_i;
	status_word[`SD_ST_WCNT_LSB +: `SD_CNT_W] = wr_count_i;
	status_word[`SD_ST_RCNT_LSB +: `SD_CNT_W] = rd_count_i;
end

// legality and read data per address
always_comb
begin
	legal = 1'b1;
	rd_word = '0;
	case (adr_i)
		ADR_STATUS:
		begin
			legal = ~we_i;
			rd_word = status_word;
		end
		ADR_CMD:
		begin
			legal = ~(we_i & cmd_busy_i);
			rd_word = last_cmd_i.raw;
		end
		// write port reads back as zero
		ADR_FIFO_WR:
			legal = ~(we_i & wr_full_i);
		ADR_FIFO_RD:
		begin
			legal = we_i | ~rd_empty_i;
			rd_word = rd_head_i;
		end
		ADR_DATA:
		begin
			legal = ~(we_i & data_busy_i);
			rd_word = last_desc_i;
		end
		default:
		begin
			if (adr_i < ADR_STATUS)
				rd_word = regs_q[adr_i[REG_IDX_W-1:0]];
			else
				legal = 1'b0;
		end
	endcase
end

always_ff @(posedge wb_clock or negedge rst_n_i)
begin
	if (!rst_n_i)
	begin
		for (int i = 0; i < `SD_NUM_REGS - 1; i++)
			regs_q[i] <= '0;
	end
	else if (reg_wr)
		regs_q[adr_i[REG_IDX_W-1:0]] <= wb_data_i;
end

// one-cycle reply with the side-effect pulses on the same edge
always_ff @(posedge wb_clock or negedge rst_n_i)
begin
	if (!rst_n_i)
	begin
		ack_o <= 1'b0;
		err_o <= 1'b0;
		cmd_we_o <= 1'b0;
		data_we_o <= 1'b0;
		wr_push_o <= 1'b0;
		rd_pop_o <= 1'b0;
	end
	else
	begin
		ack_o <= accept;
		err_o <= take & ~legal;
		cmd_we_o <= accept & we_i & (adr_i == ADR_CMD);
		data_we_o <= accept & we_i & (adr_i == ADR_DATA);
		wr_push_o <= accept & we_i & (adr_i == ADR_FIFO_WR);
		rd_pop_o <= accept & ~we_i & (adr_i == ADR_FIFO_RD);
	end
end

always_ff @(posedge wb_clock)
begin
	if (take)
	begin
		wb_data_o <= rd_word;
		exec_word_o <= wb_data_i;
	end
end

a_req_known: assert property (@(posedge wb_clock) disable iff (!rst_n_i)
	strobe_i |-> !$isunknown({we_i, adr_i}))
	else $error("bus request with unknown direction or address");

endmodule

// File: list.f
+incdir+common
+incdir+verification
common/sd_host_pkg.sv
hw/wb_regs.sv
fifo/sd_fifo.sv
exec/sd_exec_ctrl.sv
hw/sd_host_wb.sv
verification/tb_sd_host.sv

// File: verification/tb_sd_host_tasks.svh
`ifndef TB_SD_HOST_TASKS_SVH
`define TB_SD_HOST_TASKS_SVH

// all drives and samples happen this far after the rising edge
task automatic next_cycle();
	@(posedge wb_clock);
	#DRIVE_DLY;
endtask

task automatic check_word(input logic [`SD_DATA_W-1:0] got,
	input logic [`SD_DATA_W-1:0] exp, input string msg);
	checks++;
	if (got !== exp)
	begin
		errors++;
		$display("FAIL @ %0t: %s: got %h, expected %h", $time, msg, got, exp);
	end
endtask

task automatic check_flag(input logic got, input logic exp, input string msg);
	checks++;
	if (got !== exp)
	begin
		errors++;
		$display("FAIL @ %0t: %s: got %b, expected %b", $time, msg, got, exp);
	end
endtask

// index, argument and response type against the fields view
task automatic check_cmd(input sd_host_pkg::sd_cmd_word_u exp, input string msg);
	checks++;
	if ({cmd_index_o, cmd_arg_o, cmd_resp_type_o} !==
		{exp.fields.cmd_index, exp.fields.argument, exp.fields.resp_type})
	begin
		errors++;
		$display("FAIL @ %0t: %s: got index %h arg %h resp %h, expected %h %h %h",
			$time, msg, cmd_index_o, cmd_arg_o, cmd_resp_type_o,
			exp.fields.cmd_index, exp.fields.argument, exp.fields.resp_type);
	end
endtask

task automatic check_reply(input logic got_err, input logic exp_err, input string msg);
	checks++;
	if (got_err !== exp_err)
	begin
		errors++;
		$display("FAIL @ %0t: %s: got %s, expected %s", $time, msg,
			got_err ? "err" : "ack", exp_err ? "err" : "ack");
	end
endtask

// master holds the request until a reply shows up
task automatic bus_access(input logic we, input int adr, input logic [`SD_DATA_W-1:0] wdata,
	input logic exp_err, output logic [`SD_DATA_W-1:0] rdata);
	int waited;
	logic got_reply;
	waited = 0;
	got_reply = 1'b0;
	rdata = '0;
	strobe_i = 1'b1;
	we_i = we;
	adr_i = `SD_ADR_W'(adr);
	wb_data_i = wdata;
	while (!got_reply && waited < REPLY_TIMEOUT)
	begin
		next_cycle();
		waited++;
		if (ack_o || err_o)
		begin
			got_reply = 1'b1;
			rdata = wb_data_o;
			check_reply(err_o, exp_err, $sformatf("%s address %0d",
				we ? "write to" : "read of", adr));
		end
	end
	strobe_i = 1'b0;
	we_i = 1'b0;
	if (!got_reply)
	begin
		errors++;
		$display("no bus reply within %0d cycles for address %0d", REPLY_TIMEOUT, adr);
	end
	next_cycle();
endtask

task automatic bus_write(input int adr, input logic [`SD_DATA_W-1:0] data,
	input logic exp_err);
	logic [`SD_DATA_W-1:0] ignored;
	bus_access(1'b1, adr, data, exp_err, ignored);
endtask

task automatic bus_read(input int adr, input logic exp_err,
	output logic [`SD_DATA_W-1:0] data);
	bus_access(1'b0, adr, '0, exp_err, data);
endtask

`endif

// File: verification/tb_sd_host.sv
`timescale 1ns/100ps
`include "sd_host_config.svh"

module tb_sd_host;

localparam int CLK_PERIOD    = 100;
localparam int DRIVE_DLY     = 10;
localparam int RESET_CYCLES  = 10;
localparam int REPLY_TIMEOUT = 8;
localparam int N_REG_OPS     = 40;
localparam int N_UNMAP_OPS   = 16;
localparam int N_EXEC_OPS    = 4;
localparam int N_FIFO_OPS    = 48;
localparam int TOTAL_OPS     = N_REG_OPS + N_UNMAP_OPS + 2 * N_EXEC_OPS + 2 * N_FIFO_OPS;
localparam int CYCLES_PER_OP = 20;

logic                  wb_clock = 1'b0;
logic                  rst_n_i;
logic                  strobe_i;
logic                  we_i;
logic [`SD_ADR_W-1:0]  adr_i;
logic [`SD_DATA_W-1:0] wb_data_i;
logic [`SD_DATA_W-1:0] wb_data_o;
logic                  ack_o;
logic                  err_o;
logic                  cmd_start_o;
logic [5:0]            cmd_index_o;
logic [31:0]           cmd_arg_o;
logic [1:0]            cmd_resp_type_o;
logic                  cmd_done_i;
logic                  data_start_o;
logic [`SD_DATA_W-1:0] data_desc_o;
logic                  data_done_i;
logic [`SD_DATA_W-1:0] host_data_i;
logic                  host_data_valid_i;
logic [`SD_DATA_W-1:0] host_data_o;
logic                  host_data_pop_i;
logic                  fifo_write_wait_o;
logic                  fifo_read_wait_o;

integer seed;
int     errors;
int     checks;
// reference model
logic [`SD_DATA_W-1:0] shadow [0:`SD_NUM_REGS-2];
logic [`SD_DATA_W-1:0] wq [$];
logic [`SD_DATA_W-1:0] rq [$];
logic                  cmd_busy_m;
logic                  data_busy_m;

sd_host_wb u_dut (
	.wb_clock          (wb_clock),
	.rst_n_i           (rst_n_i),
	.strobe_i          (strobe_i),
	.we_i              (we_i),
	.adr_i             (adr_i),
	.wb_data_i         (wb_data_i),
	.wb_data_o         (wb_data_o),
	.ack_o             (ack_o),
	.err_o             (err_o),
	.cmd_start_o       (cmd_start_o),
	.cmd_index_o       (cmd_index_o),
	.cmd_arg_o         (cmd_arg_o),
	.cmd_resp_type_o   (cmd_resp_type_o),
	.cmd_done_i        (cmd_done_i),
	.data_start_o      (data_start_o),
	.data_desc_o       (data_desc_o),
	.data_done_i       (data_done_i),
	.host_data_i       (host_data_i),
	.host_data_valid_i (host_data_valid_i),
	.host_data_o       (host_data_o),
	.host_data_pop_i   (host_data_pop_i),
	.fifo_write_wait_o (fifo_write_wait_o),
	.fifo_read_wait_o  (fifo_read_wait_o)
);

always #(CLK_PERIOD / 2) wb_clock = ~wb_clock;

`include "tb_sd_host_tasks.svh"

function automatic int rand_below(input int n);
	return int'(($random(seed) & 32'h7fff_ffff) % n);
endfunction

function automatic logic [`SD_DATA_W-1:0] rand_word();
	return {$random(seed), $random(seed), $random(seed), $random(seed)};
endfunction

// status layout: busy bits low, then the two fifo counts
function automatic logic [`SD_DATA_W-1:0] expected_status();
	logic [`SD_DATA_W-1:0] w;
	w = '0;
	w[`SD_ST_CMD_BUSY] = cmd_busy_m;
	w[`SD_ST_DATA_BUSY] = data_busy_m;
	w[`SD_ST_WCNT_LSB +: `SD_CNT_W] = `SD_CNT_W'(wq.size());
	w[`SD_ST_RCNT_LSB +: `SD_CNT_W] = `SD_CNT_W'(rq.size());
	return w;
endfunction

task automatic check_status(input string msg);
	logic [`SD_DATA_W-1:0] rd;
	bus_read(`SD_STATUS_REG, 1'b0, rd);
	check_word(rd, expected_status(), msg);
endtask

task automatic wait_start(input bit data_ch);
	int waited;
	waited = 0;
	while ((data_ch ? data_start_o : cmd_start_o) !== 1'b1 && waited < REPLY_TIMEOUT)
	begin
		next_cycle();
		waited++;
	end
	if ((data_ch ? data_start_o : cmd_start_o) !== 1'b1)
	begin
		errors++;
		$display("%s start pulse never appeared", data_ch ? "data" : "command");
	end
endtask

task automatic pulse_done(input bit data_ch);
	if (data_ch)
		data_done_i = 1'b1;
	else
		cmd_done_i = 1'b1;
	next_cycle();
	data_done_i = 1'b0;
	cmd_done_i = 1'b0;
endtask

// sd side drains the write fifo, head checked before each pop
task automatic pop_host_word();
	check_word(host_data_o, wq.pop_front(), "host data order");
	host_data_pop_i = 1'b1;
	next_cycle();
	host_data_pop_i = 1'b0;
endtask

task automatic push_card_word();
	host_data_i = rand_word();
	host_data_valid_i = 1'b1;
	next_cycle();
	host_data_valid_i = 1'b0;
	rq.push_back(host_data_i);
endtask

task automatic run_reset_and_regs();
	logic [`SD_DATA_W-1:0] rd;
	logic [`SD_DATA_W-1:0] wr;
	int idx;
	check_flag(ack_o, 1'b0, "ack after reset");
	check_flag(err_o, 1'b0, "err after reset");
	check_flag(cmd_start_o, 1'b0, "command start after reset");
	check_flag(data_start_o, 1'b0, "data start after reset");
	check_flag(fifo_read_wait_o, 1'b1, "read wait after reset");
	check_flag(fifo_write_wait_o, 1'b0, "write wait after reset");
	check_status("status after reset");
	for (int i = 0; i < N_REG_OPS; i++)
	begin
		idx = rand_below(`SD_NUM_REGS - 1);
		wr = rand_word();
		bus_write(idx, wr, 1'b0);
		shadow[idx] = wr;
		idx = rand_below(`SD_NUM_REGS - 1);
		bus_read(idx, 1'b0, rd);
		check_word(rd, shadow[idx], $sformatf("register %0d readback", idx));
	end
	bus_write(`SD_STATUS_REG, rand_word(), 1'b1);
	check_status("status after refused write");
endtask

task automatic run_unmapped();
	logic [`SD_DATA_W-1:0] rd;
	int adr;
	for (int i = 0; i < N_UNMAP_OPS; i++)
	begin
		adr = `SD_ADR_DATA + 1 + rand_below((1 << `SD_ADR_W) - `SD_ADR_DATA - 1);
		if (rand_below(2) == 1)
			bus_write(adr, rand_word(), 1'b1);
		else
			bus_read(adr, 1'b1, rd);
	end
	for (int i = 0; i < `SD_NUM_REGS - 1; i++)
	begin
		bus_read(i, 1'b0, rd);
		check_word(rd, shadow[i], $sformatf("register %0d after unmapped accesses", i));
	end
endtask

// same sequence for the command and the data channel
task automatic run_exec(input bit data_ch);
	sd_host_pkg::sd_cmd_word_u word;
	logic [`SD_DATA_W-1:0] rd;
	int adr;
	adr = data_ch ? `SD_ADR_DATA : `SD_ADR_CMD;
	for (int i = 0; i < N_EXEC_OPS; i++)
	begin
		word.raw = rand_word();
		bus_write(adr, word.raw, 1'b0);
		if (data_ch)
			data_busy_m = 1'b1;
		else
			cmd_busy_m = 1'b1;
		wait_start(data_ch);
		if (data_ch)
			check_word(data_desc_o, word.raw, "data descriptor at start");
		else
			check_cmd(word, "command fields at start");
		next_cycle();
		check_flag(data_ch ? data_start_o : cmd_start_o, 1'b0, "start lasts one cycle");
		check_status("status while channel busy");
		bus_write(adr, rand_word(), 1'b1);
		pulse_done(data_ch);
		data_busy_m = 1'b0;
		cmd_busy_m = 1'b0;
		check_status("status after done");
		bus_read(adr, 1'b0, rd);
		check_word(rd, word.raw, "execute word readback");
	end
endtask

task automatic run_write_fifo();
	logic [`SD_DATA_W-1:0] rd;
	logic [`SD_DATA_W-1:0] wr;
	for (int i = 0; i < N_FIFO_OPS; i++)
	begin
		if (wq.size() < `SD_FIFO_DEPTH && (wq.size() == 0 || rand_below(2) == 1))
		begin
			wr = rand_word();
			bus_write(`SD_ADR_FIFO_WR, wr, 1'b0);
			wq.push_back(wr);
		end
		else
			pop_host_word();
		check_flag(fifo_write_wait_o, wq.size() == `SD_FIFO_DEPTH, "write wait level");
	end
	check_status("status during write fifo traffic");
	while (wq.size() > 0)
		pop_host_word();
	while (wq.size() < `SD_FIFO_DEPTH)
	begin
		wr = rand_word();
		bus_write(`SD_ADR_FIFO_WR, wr, 1'b0);
		wq.push_back(wr);
	end
	check_flag(fifo_write_wait_o, 1'b1, "write wait with full fifo");
	bus_write(`SD_ADR_FIFO_WR, rand_word(), 1'b1);
	check_status("status with full write fifo");
	bus_read(`SD_ADR_FIFO_WR, 1'b0, rd);
	check_word(rd, '0, "write port readback");
	while (wq.size() > 0)
		pop_host_word();
endtask

task automatic run_read_fifo();
	logic [`SD_DATA_W-1:0] rd;
	for (int i = 0; i < N_FIFO_OPS; i++)
	begin
		if (rq.size() < `SD_FIFO_DEPTH && rand_below(2) == 1)
			push_card_word();
		else if (rq.size() > 0)
		begin
			bus_read(`SD_ADR_FIFO_RD, 1'b0, rd);
			check_word(rd, rq.pop_front(), "read fifo order");
		end
		else
			bus_read(`SD_ADR_FIFO_RD, 1'b1, rd);
		check_flag(fifo_read_wait_o, rq.size() == 0, "read wait level");
	end
	check_status("status during read fifo traffic");
	while (rq.size() > 0)
	begin
		bus_read(`SD_ADR_FIFO_RD, 1'b0, rd);
		check_word(rd, rq.pop_front(), "read fifo drain order");
	end
	bus_read(`SD_ADR_FIFO_RD, 1'b1, rd);
	check_status("status with empty read fifo");
endtask

// watchdog sized from the operation count
initial
begin
	#((TOTAL_OPS * CYCLES_PER_OP + RESET_CYCLES) * CLK_PERIOD);
	$display("timeout: tests did not finish within %0d cycles",
		TOTAL_OPS * CYCLES_PER_OP + RESET_CYCLES);
	$display("*** FAILED ***");
	$finish;
end

initial
begin
	rst_n_i = 1'b0;
	strobe_i = 1'b0;
	we_i = 1'b0;
	adr_i = '0;
	wb_data_i = '0;
	cmd_done_i = 1'b0;
	data_done_i = 1'b0;
	host_data_i = '0;
	host_data_valid_i = 1'b0;
	host_data_pop_i = 1'b0;
	seed = 19;
	errors = 0;
	checks = 0;
	cmd_busy_m = 1'b0;
	data_busy_m = 1'b0;
	for (int i = 0; i < `SD_NUM_REGS - 1; i++)
		shadow[i] = '0;
	repeat (RESET_CYCLES) @(posedge wb_clock);
	#DRIVE_DLY;
	rst_n_i = 1'b1;
	run_reset_and_regs();
	run_unmapped();
	run_exec(1'b0);
	run_exec(1'b1);
	run_write_fifo();
	run_read_fifo();
	$display("checks: %0d, errors: %0d", checks, errors);
	if (errors == 0)
		$display("*** PASSED ***");
	else
		$display("*** FAILED ***");
	$finish;
end

endmodule
